// File: list.f
design/encoder_data_pkg.sv
design/encoder_cfg_pkg.sv
design/residual_bus_if.sv
design/fixed_encoder_order2.sv
design/fixed_encoder_order4.sv
design/block_cost_selector.sv
design/encoder_config_regs.sv
design/flac_fixed_encoder.sv
test/tb_flac_fixed_encoder.sv

// File: test/tb_flac_fixed_encoder.sv
`timescale 1ns/100ps

module tb_flac_fixed_encoder;
    import encoder_data_pkg::*;
    import encoder_cfg_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int DEFAULT_LEN  = 64;
    localparam int LATENCY      = 7;
    localparam int WARMUP       = 4;
    // Outputs after this enabled edge carry the first valid residual
    localparam int FIRST_VALID  = WARMUP + 1 + LATENCY;

    localparam int RAMP_N     = 40;
    localparam int PARA_N     = 40;
    localparam int RAND_N     = 200;
    localparam int STALL_N    = 120;
    localparam int BLOCK_N    = 64;
    localparam int OVR_N      = 48;
    localparam int ZERO_N     = 40;
    localparam int RESETS     = 6;
    localparam int CFG_WRITES = 6;
    // Stalls add up to three idle cycles per sample
    localparam int TOTAL_CYCLES = RAMP_N + PARA_N + RAND_N + 4 * STALL_N + 2 * BLOCK_N
                                + 2 * OVR_N + ZERO_N + RESETS * (RESET_CYCLES + 2)
                                + CFG_WRITES;
    localparam int TIMEOUT_NS = 2 * TOTAL_CYCLES * CLK_PERIOD;

    logic                  iClock;
    logic                  reset;
    logic                  enable;
    sample_t               sample;
    logic                  cfg_write;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_data;
    residual_t             residual2;
    residual_t             residual4;
    logic                  residual_valid;
    logic                  block_done;
    order_t                best_order;
    cost_t                 cost2;
    cost_t                 cost4;

    logic [31:0] lfsr;
    string       test_name;
    int          errors;
    int          checks;

    // Reference model state
    sample_t     samples[$];
    int          en_count;
    int          len_reg;
    logic        ovr_en;
    logic        ovr_order;
    int          cnt;
    int          active_len;
    longint      acc2;
    longint      acc4;
    longint      exp_cost2;
    longint      exp_cost4;
    int          exp_best;
    logic        exp_done;

    flac_fixed_encoder #(
        .BLOCK_LEN_W       (16),
        .DEFAULT_BLOCK_LEN (DEFAULT_LEN)
    ) flac_fixed_encoder_inst (
        .iClock         (iClock),
        .reset          (reset),
        .enable         (enable),
        .sample         (sample),
        .cfg_write      (cfg_write),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .residual2      (residual2),
        .residual4      (residual4),
        .residual_valid (residual_valid),
        .block_done     (block_done),
        .best_order     (best_order),
        .cost2          (cost2),
        .cost4          (cost4)
    );

    initial begin
        iClock = 1'b0;
        forever #(CLK_PERIOD / 2) iClock = ~iClock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hA300_0000;
        end else begin
            return state >> 1;
        end
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // Second difference of sample k (1-based) wrapped to 16 bits
    function automatic int pred2_error(input int k);
        int v;
        v = int'(samples[k-1]) - 2 * int'(samples[k-2]) + int'(samples[k-3]);
        return int'(residual_t'(v));
    endfunction

    // Fourth difference of sample k wrapped to 16 bits
    function automatic int pred4_error(input int k);
        int v;
        v = int'(samples[k-1]) - 4 * int'(samples[k-2]) + 6 * int'(samples[k-3])
          - 4 * int'(samples[k-4]) + int'(samples[k-5]);
        return int'(residual_t'(v));
    endfunction

    // Residual seen on the outputs after enabled edge e
    function automatic int expected_res(input int e, input bit fourth);
        int k;
        k = e - LATENCY;
        if (k <= WARMUP) begin
            return 0;
        end
        return fourth ? pred4_error(k) : pred2_error(k);
    endfunction

    function automatic longint magnitude(input int r);
        return (r < 0) ? -r : r;
    endfunction

    task automatic check_value(input string what, input longint expected, input longint actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // Selector side of the model takes the residual on the bus at this edge
    task automatic model_edge(input sample_t s);
        if (en_count >= FIRST_VALID) begin
            if (cnt == 0) begin
                active_len = len_reg;
            end
            acc2 += magnitude(expected_res(en_count, 1'b0));
            acc4 += magnitude(expected_res(en_count, 1'b1));
            cnt++;
            if (cnt == active_len) begin
                exp_cost2 = acc2;
                exp_cost4 = acc4;
                if (ovr_en) begin
                    exp_best = ovr_order;
                end else begin
                    // Strictly cheaper wins and ties stay with order 2
                    exp_best = (acc4 < acc2) ? 1 : 0;
                end
                exp_done = 1'b1;
                acc2     = 0;
                acc4     = 0;
                cnt      = 0;
            end
        end
        samples.push_back(s);
        en_count++;
    endtask

    task automatic compare_outputs();
        check_value("residual2", expected_res(en_count, 1'b0), residual2);
        check_value("residual4", expected_res(en_count, 1'b1), residual4);
        check_value("residual_valid", en_count >= FIRST_VALID, residual_valid);
        check_value("block_done", exp_done, block_done);
        check_value("best_order", exp_best, best_order);
        check_value("cost2", exp_cost2, cost2);
        check_value("cost4", exp_cost4, cost4);
    endtask

    // Starts at a falling edge and returns at the next one
    task automatic step(input logic en, input sample_t s);
        enable = en;
        sample = s;
        @(posedge iClock);
        exp_done = 1'b0;
        if (en) begin
            model_edge(s);
        end
        @(negedge iClock);
        compare_outputs();
    endtask

    task automatic write_cfg(input logic [CFG_ADDR_W-1:0] addr,
                             input logic [CFG_DATA_W-1:0] data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        step(1'b0, sample);
        cfg_write = 1'b0;
        if (addr == ADDR_BLOCK_LEN) begin
            len_reg = (data[15:0] == 16'd0) ? 1 : int'(data[15:0]);
        end else if (addr == ADDR_OVERRIDE) begin
            ovr_en    = data[OVR_EN_BIT];
            ovr_order = data[OVR_ORDER_BIT];
        end
    endtask

    task automatic apply_reset();
        reset     = 1'b1;
        enable    = 1'b0;
        cfg_write = 1'b0;
        repeat (RESET_CYCLES) @(posedge iClock);
        @(negedge iClock);
        reset = 1'b0;
        samples.delete();
        en_count   = 0;
        len_reg    = DEFAULT_LEN;
        ovr_en     = 1'b0;
        ovr_order  = 1'b0;
        cnt        = 0;
        active_len = 0;
        acc2       = 0;
        acc4       = 0;
        exp_cost2  = 0;
        exp_cost4  = 0;
        exp_best   = 0;
        exp_done   = 1'b0;
    endtask

    task automatic ramp_and_parabola();
        test_name = "ramp";
        apply_reset();
        for (int i = 0; i < RAMP_N; i++) begin
            step(1'b1, sample_t'(37 * i - 700));
            if (residual_valid) begin
                check_value("linear order-2 residual", 0, residual2);
            end
        end
        test_name = "parabola";
        apply_reset();
        for (int i = 0; i < PARA_N; i++) begin
            step(1'b1, sample_t'(i * i - 900));
            if (residual_valid) begin
                // Second difference of i*i is 2 everywhere
                check_value("quadratic order-2 residual", 2, residual2);
                check_value("quadratic order-4 residual", 0, residual4);
            end
        end
    endtask

    task automatic random_samples();
        logic [31:0] bits;
        bit          risen;
        sample_t     s;
        test_name = "random";
        apply_reset();
        risen = 1'b0;
        for (int i = 0; i < RAND_N; i++) begin
            draw_bits(16, bits);
            s = sample_t'(bits[15:0]);
            // Now and then hit the rails to force the wrap
            if (i % 10 == 9) begin
                s = bits[0] ? 16'sh7fff : 16'sh8000;
            end
            step(1'b1, s);
            if (residual_valid && !risen) begin
                risen = 1'b1;
                check_value("valid rise sample", WARMUP + 1, en_count - LATENCY);
            end
        end
        if (!risen) begin
            errors++;
            $display("random: residual_valid never went high");
        end
    endtask

    task automatic enable_stalls();
        logic [31:0] bits;
        logic [31:0] gap;
        residual_t   held2;
        residual_t   held4;
        test_name = "stalls";
        apply_reset();
        for (int i = 0; i < STALL_N; i++) begin
            draw_bits(2, gap);
            held2 = residual2;
            held4 = residual4;
            for (int g = 0; g < int'(gap); g++) begin
                // Input keeps changing while the pipe is stalled
                draw_bits(16, bits);
                step(1'b0, sample_t'(bits[15:0]));
                check_value("residual2 held", held2, residual2);
                check_value("residual4 held", held4, residual4);
            end
            draw_bits(16, bits);
            step(1'b1, sample_t'(bits[15:0]));
        end
    endtask

    task automatic block_costs();
        logic [31:0] bits;
        int          blocks;
        test_name = "block costs";
        apply_reset();
        write_cfg(ADDR_BLOCK_LEN, 32'd16);
        blocks = 0;
        // Quadratic first so order 4 wins and then noise
        for (int i = 0; i < BLOCK_N; i++) begin
            step(1'b1, sample_t'(i * i - 2000));
            if (block_done) begin
                blocks++;
                check_value("quadratic best order", ORDER_4, best_order);
            end
        end
        for (int i = 0; i < BLOCK_N; i++) begin
            draw_bits(16, bits);
            step(1'b1, sample_t'(bits[15:0]));
            if (block_done) begin
                blocks++;
            end
        end
        check_value("block_done pulses", (2 * BLOCK_N - FIRST_VALID + 1) / 16, blocks);
    endtask

    task automatic override_and_zero_len();
        logic [31:0] bits;
        test_name = "override";
        apply_reset();
        write_cfg(ADDR_BLOCK_LEN, 32'd8);
        write_cfg(ADDR_OVERRIDE, (32'd1 << OVR_EN_BIT) | (32'(ORDER_4) << OVR_ORDER_BIT));
        for (int i = 0; i < OVR_N; i++) begin
            draw_bits(16, bits);
            step(1'b1, sample_t'(bits[15:0]));
            if (block_done) begin
                check_value("forced order 4", ORDER_4, best_order);
            end
        end
        write_cfg(ADDR_OVERRIDE, (32'd1 << OVR_EN_BIT) | (32'(ORDER_2) << OVR_ORDER_BIT));
        for (int i = 0; i < OVR_N; i++) begin
            step(1'b1, sample_t'(i * i - 2000));
            if (block_done) begin
                check_value("forced order 2", ORDER_2, best_order);
            end
        end
        test_name = "zero length";
        write_cfg(ADDR_BLOCK_LEN, 32'd0);
        for (int i = 0; i < ZERO_N; i++) begin
            draw_bits(16, bits);
            step(1'b1, sample_t'(bits[15:0]));
            // The running block of eight has ended by now
            if (i >= 8) begin
                check_value("done on every sample", 1, block_done);
            end
        end
    endtask

    initial begin
        lfsr      = 32'h7e8f;
        errors    = 0;
        checks    = 0;
        test_name = "init";
        reset     = 1'b1;
        enable    = 1'b0;
        sample    = '0;
        cfg_write = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        ramp_and_parabola();
        random_samples();
        enable_stalls();
        block_costs();
        override_and_zero_len();
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: design/flac_fixed_encoder.sv
`timescale 1ns/100ps

module flac_fixed_encoder #(
    parameter int BLOCK_LEN_W       = 16,
    parameter int DEFAULT_BLOCK_LEN = 64
) (
    input  logic                                  iClock,
    input  logic                                  reset,
    input  logic                                  enable,
    input  encoder_data_pkg::sample_t             sample,
    input  logic                                  cfg_write,
    input  logic [encoder_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [encoder_cfg_pkg::CFG_DATA_W-1:0] cfg_data,
    output encoder_data_pkg::residual_t           residual2,
    output encoder_data_pkg::residual_t           residual4,
    output logic                                  residual_valid,
    output logic                                  block_done,
    output encoder_data_pkg::order_t              best_order,
    output encoder_data_pkg::cost_t               cost2,
    output encoder_data_pkg::cost_t               cost4
);
    import encoder_data_pkg::*;

    logic [BLOCK_LEN_W-1:0] block_len;
    logic                   override_en;
    order_t                 override_order;

    residual_bus_if res_bus ();

    encoder_config_regs #(
        .BLOCK_LEN_W       (BLOCK_LEN_W),
        .DEFAULT_BLOCK_LEN (DEFAULT_BLOCK_LEN)
    ) encoder_config_regs_inst (
        .iClock         (iClock),
        .reset          (reset),
        .cfg_write      (cfg_write),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .block_len      (block_len),
        .override_en    (override_en),
        .override_order (override_order)
    );

    // Both predictors share the enable so their residuals stay aligned
    fixed_encoder_order2 fixed_encoder_order2_inst (
        .iClock (iClock),
        .reset  (reset),
        .enable (enable),
        .sample (sample),
        .bus    (res_bus.producer2)
    );

    fixed_encoder_order4 fixed_encoder_order4_inst (
        .iClock (iClock),
        .reset  (reset),
        .enable (enable),
        .sample (sample),
        .bus    (res_bus.producer4)
    );

    block_cost_selector #(
        .BLOCK_LEN_W (BLOCK_LEN_W)
    ) block_cost_selector_inst (
        .iClock         (iClock),
        .reset          (reset),
        .enable         (enable),
        .bus            (res_bus.consumer),
        .block_len      (block_len),
        .override_en    (override_en),
        .override_order (override_order),
        .block_done     (block_done),
        .best_order     (best_order),
        .cost2          (cost2),
        .cost4          (cost4)
    );

    assign residual2      = res_bus.res2;
    assign residual4      = res_bus.res4;
    assign residual_valid = res_bus.valid;

endmodule

// File: design/encoder_config_regs.sv
`timescale 1ns/100ps

module encoder_config_regs #(
    parameter int BLOCK_LEN_W       = 16,
    parameter int DEFAULT_BLOCK_LEN = 64
) (
    input  logic                                  iClock,
    input  logic                                  reset,
    input  logic                                  cfg_write,
    input  logic [encoder_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [encoder_cfg_pkg::CFG_DATA_W-1:0] cfg_data,
    output logic [BLOCK_LEN_W-1:0]                block_len,
    output logic                                  override_en,
    output encoder_data_pkg::order_t              override_order
);
    import encoder_data_pkg::*;
    import encoder_cfg_pkg::*;

    logic [BLOCK_LEN_W-1:0] len_field;

    // Block length sits in the low bits of the data word
    assign len_field = cfg_data[BLOCK_LEN_W-1:0];

    always_ff @(posedge iClock) begin
        if (reset) begin
            block_len      <= BLOCK_LEN_W'(DEFAULT_BLOCK_LEN);
            override_en    <= RST_OVERRIDE_EN;
            override_order <= order_t'(RST_OVERRIDE_ORDER);
        end else if (cfg_write) begin
            case (cfg_addr)
                ADDR_BLOCK_LEN: begin
                    // Zero would mean an empty block, use one instead
                    if (len_field == '0) begin
                        block_len <= BLOCK_LEN_W'(1);
                    end else begin
                        block_len <= len_field;
                    end
                end
                ADDR_OVERRIDE: begin
                    override_en    <= cfg_data[OVR_EN_BIT];
                    override_order <= order_t'(cfg_data[OVR_ORDER_BIT]);
                end
                default: begin
                    // Unmapped addresses are ignored
                end
            endcase
        end
    end

endmodule

// File: design/block_cost_selector.sv
`timescale 1ns/100ps

module block_cost_selector #(
    parameter int BLOCK_LEN_W = 16
) (
    input  logic                      iClock,
    input  logic                      reset,
    input  logic                      enable,
    residual_bus_if.consumer          bus,
    input  logic [BLOCK_LEN_W-1:0]    block_len,
    input  logic                      override_en,
    input  encoder_data_pkg::order_t  override_order,
    output logic                      block_done,
    output encoder_data_pkg::order_t  best_order,
    output encoder_data_pkg::cost_t   cost2,
    output encoder_data_pkg::cost_t   cost4
);
    import encoder_data_pkg::*;

    logic [BLOCK_LEN_W-1:0] count;
    logic [BLOCK_LEN_W-1:0] count_next;
    logic [BLOCK_LEN_W-1:0] active_len;
    logic [BLOCK_LEN_W-1:0] len_now;
    logic [16:0]            abs2;
    logic [16:0]            abs4;
    cost_t                  acc2;
    cost_t                  acc4;
    cost_t                  sum2;
    cost_t                  sum4;
    logic                   take;
    logic                   block_end;

    // One bit wider so that -32768 maps to 32768
    function automatic logic [16:0] magnitude(input residual_t r);
        logic signed [16:0] wide;
        wide = r;
        return wide[16] ? 17'(-wide) : 17'(wide);
    endfunction

    assign abs2 = magnitude(bus.res2);
    assign abs4 = magnitude(bus.res4);
    assign sum2 = acc2 + cost_t'(abs2);
    assign sum4 = acc4 + cost_t'(abs4);

    // First residual of a block picks up the current register value
    assign len_now    = (count == '0) ? block_len : active_len;
    assign count_next = count + 1'b1;

    assign take      = enable && bus.valid;
    assign block_end = take && (count_next == len_now);

    always_ff @(posedge iClock) begin
        if (reset) begin
            count      <= '0;
            active_len <= '0;
            acc2       <= '0;
            acc4       <= '0;
            cost2      <= '0;
            cost4      <= '0;
            best_order <= ORDER_2;
            block_done <= 1'b0;
        end else begin
            block_done <= 1'b0;
            if (take) begin
                if (count == '0) begin
                    active_len <= block_len;
                end
                if (block_end) begin
                    cost2 <= sum2;
                    cost4 <= sum4;
                    // Ties go to order 2
                    if (override_en) begin
                        best_order <= override_order;
                    end else begin
                        best_order <= (sum4 < sum2) ? ORDER_4 : ORDER_2;
                    end
                    block_done <= 1'b1;
                    acc2       <= '0;
                    acc4       <= '0;
                    count      <= '0;
                end else begin
                    acc2  <= sum2;
                    acc4  <= sum4;
                    count <= count_next;
                end
            end
        end
    end

    // Back-to-back done pulses only come from one-sample blocks
    done_single_pulse: assert property (
        @(posedge iClock) disable iff (reset)
        (block_done && block_len != BLOCK_LEN_W'(1)) |=> !block_done
    );

endmodule

// File: design/fixed_encoder_order4.sv
`timescale 1ns/100ps

module fixed_encoder_order4 (
    input  logic                      iClock,
    input  logic                      reset,
    input  logic                      enable,
    input  encoder_data_pkg::sample_t sample,
    residual_bus_if.producer4         bus
);
    import encoder_data_pkg::*;

    // Delay stages between the phase-three result and the bus register
    localparam int PAD_DEPTH = PIPE_LATENCY - 5;

    sample_t                 sample_r;
    sample_t                 hist [0:4];
    residual_t               outer;
    residual_t               inner4;
    residual_t               center6;
    residual_t               pos_sum;
    residual_t               neg_sum;
    residual_t               res_p3;
    residual_t               pad [0:PAD_DEPTH-1];
    logic [3:0]              warmup;
    logic [PIPE_LATENCY-1:0] live;

    // x0 - 4x1 + 6x2 - 4x3 + x4, all terms wrap at 16 bits
    always_ff @(posedge iClock) begin
        if (enable) begin
            sample_r <= sample;
            hist[0]  <= sample_r;
            for (int i = 1; i < 5; i++) begin
                hist[i] <= hist[i-1];
            end

            // Phase one, outer pair, inner pair times four, centre times six
            outer   <= hist[0] + hist[4];
            inner4  <= (hist[1] + hist[3]) <<< 2;
            center6 <= (hist[2] <<< 2) + (hist[2] <<< 1);

            // Phase two, collect positive and negative parts
            pos_sum <= outer + center6;
            neg_sum <= inner4;
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            warmup    <= '0;
            live      <= '0;
            res_p3    <= '0;
            for (int i = 0; i < PAD_DEPTH; i++) begin
                pad[i] <= '0;
            end
            bus.res4  <= '0;
            bus.valid <= 1'b0;
        end else if (enable) begin
            warmup <= {warmup[2:0], 1'b1};

            // Live tag follows each sample down the pipe
            live <= {live[PIPE_LATENCY-2:0], warmup[3]};

            // Phase three
            res_p3 <= live[3] ? residual_t'(pos_sum - neg_sum) : '0;

            pad[0] <= res_p3;
            for (int i = 1; i < PAD_DEPTH; i++) begin
                pad[i] <= pad[i-1];
            end
            bus.res4 <= pad[PAD_DEPTH-1];

            // Valid lands on the same edge as the first live residual
            bus.valid <= live[PIPE_LATENCY-1];
        end
    end

    // Once the history is full it stays full until the next reset
    valid_never_falls: assert property (
        @(posedge iClock) disable iff (reset)
        bus.valid |=> bus.valid
    );

endmodule

// File: design/fixed_encoder_order2.sv
`timescale 1ns/100ps

module fixed_encoder_order2 (
    input  logic                      iClock,
    input  logic                      reset,
    input  logic                      enable,
    input  encoder_data_pkg::sample_t sample,
    residual_bus_if.producer2         bus
);
    import encoder_data_pkg::*;

    // Delay stages between the phase-two result and the bus register
    localparam int PAD_DEPTH = PIPE_LATENCY - 4;

    sample_t    sample_r;
    sample_t    hist [0:2];
    residual_t  term_a;
    residual_t  term_b;
    residual_t  diff;
    residual_t  pad [0:PAD_DEPTH-1];
    logic [3:0] warmup;
    logic [2:0] live;

    // Sample history and phase one, x0 + x2 and 2*x1
    always_ff @(posedge iClock) begin
        if (enable) begin
            sample_r <= sample;
            hist[0]  <= sample_r;
            hist[1]  <= hist[0];
            hist[2]  <= hist[1];
            term_a   <= hist[0] + hist[2];
            term_b   <= hist[1] <<< 1;
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            warmup   <= '0;
            live     <= '0;
            diff     <= '0;
            for (int i = 0; i < PAD_DEPTH; i++) begin
                pad[i] <= '0;
            end
            bus.res2 <= '0;
        end else if (enable) begin
            // Four enabled edges of warmup, then samples are tagged live
            warmup <= {warmup[2:0], 1'b1};
            live   <= {live[1:0], warmup[3]};

            // Phase two, held at zero until the tagged sample reaches it
            diff <= live[2] ? residual_t'(term_a - term_b) : '0;

            // Pad out to the order-4 latency
            pad[0] <= diff;
            for (int i = 1; i < PAD_DEPTH; i++) begin
                pad[i] <= pad[i-1];
            end
            bus.res2 <= pad[PAD_DEPTH-1];
        end
    end

    // A stalled pipeline keeps its residual on the bus
    res2_hold_on_stall: assert property (
        @(posedge iClock) disable iff (reset)
        !enable |=> $stable(bus.res2)
    );

endmodule

// File: design/residual_bus_if.sv
`timescale 1ns/100ps

interface residual_bus_if;
    import encoder_data_pkg::*;

    // Both residuals line up on the same enabled edge
    residual_t res2;
    residual_t res4;

    // Level, high once the order-4 history holds real samples
    logic      valid;

    // Order-2 predictor owns only its residual
    modport producer2 (
        output res2
    );

    // Order-4 predictor has the longer warmup so it also owns valid
    modport producer4 (
        output res4,
        output valid
    );

    // Block cost selector
    modport consumer (
        input res2,
        input res4,
        input valid
    );

endinterface

// File: design/encoder_cfg_pkg.sv
package encoder_cfg_pkg;

    // Register bus geometry
    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 32;

    // Register map
    localparam logic [CFG_ADDR_W-1:0] ADDR_BLOCK_LEN = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] ADDR_OVERRIDE  = 2'd1;

    // Override register layout, enable bit plus one order code bit
    localparam int OVR_EN_BIT    = 0;
    localparam int OVR_ORDER_BIT = 1;

    // Override register contents after reset
    localparam logic RST_OVERRIDE_EN    = 1'b0;
    localparam logic RST_OVERRIDE_ORDER = 1'b0;

endpackage

// File: design/encoder_data_pkg.sv
package encoder_data_pkg;

    // Audio sample as it arrives from the input stage
    typedef logic signed [15:0] sample_t;

    // Prediction error, kept at sample width and wrapping modulo 2^16
    typedef logic signed [15:0] residual_t;

    // Sum of absolute residuals over one block
    typedef logic [31:0] cost_t;

    // Predictor order code reported by the selector
    typedef enum logic {
        ORDER_2 = 1'b0,
        ORDER_4 = 1'b1
    } order_t;

    // Enabled edges from sample capture to its residual on the bus
    localparam int PIPE_LATENCY = 7;

endpackage
